/* tb.f */
rtl/up_link_pkg.sv
rtl/up_byte_port.sv
rtl/up_interface_fsm.sv
rtl/wb_reg_bank.sv
rtl/up_link_top.sv
testbench/tb_up_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f tb.f --top-module tb_up_link -o sim_up_link \
  && ./obj_dir/sim_up_link | tee sim.log \
  && grep -qx "sim passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

/* testbench/tb_up_link.sv */
// Directed testbench for the processor link.
// Models the external processor on both handshake channels, runs write and
// read frames into the register bank and predicts every read from a
// reference copy of the registers and the write count.

`default_nettype none

module tb_up_link import up_link_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FRAME_LIMIT = 40;
  localparam int FRAME_CYCLES = 200;
  localparam int TIMEOUT_CYCLES = FRAME_LIMIT * FRAME_CYCLES;
  localparam int GAP_CYCLES = 8;
  localparam cmd_t WRITE_FLAG = 8'h80;
  localparam reg_addr_t COUNT_ADDR = 3'd7;

  logic  clk;
  logic  reset;
  logic  soft_reset;
  logic  start;
  byte_t up_data_in;
  logic  hs_in_req;
  logic  hs_out_ack;
  byte_t up_data_out;
  logic  rw;
  logic  hs_in_ack;
  logic  hs_out_req;

  word_t  ref_regs [8];
  word_t  ref_writes;
  int     errors = 0;
  int     checks = 0;
  int     cycle_count = 0;
  int     max_delay = 0;
  integer seed;

  up_link_top #(
    .SYNC_STAGES(2)
  ) u_up_link_top (
    .clk, .reset, .soft_reset, .start, .up_data_in, .hs_in_req, .hs_out_ack,
    .up_data_out, .rw, .hs_in_ack, .hs_out_req
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: link stopped responding");
      $display("sim failed");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // a slow processor waits a random number of cycles before it answers.
  task automatic answer_pause();
    int n;
    n = 0;
    if (max_delay > 0) begin
      n = $unsigned($random(seed)) % (max_delay + 1);
    end
    idle_cycles(n);
  endtask

  task automatic compare_word(input word_t actual, input word_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic compare_byte(input byte_t actual, input byte_t expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic compare_bit(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s expected %b, got %b", $time, what, expected, actual);
    end
  endtask

  task automatic send_byte(input byte_t value);
    up_data_in = value;
    hs_in_req  = 1'b1;
    while (hs_in_ack !== 1'b1) begin
      next_cycle();
    end
    compare_bit(rw, 1'b0, "rw while the link receives");
    answer_pause();
    hs_in_req = 1'b0;  // data stays put until the next byte.
    while (hs_in_ack !== 1'b0) begin
      next_cycle();
    end
  endtask

  task automatic receive_byte(output byte_t value);
    while (hs_out_req !== 1'b1) begin
      next_cycle();
    end
    compare_bit(rw, 1'b1, "rw while the link returns data");
    value = up_data_out;
    answer_pause();
    hs_out_ack = 1'b1;
    while (hs_out_req !== 1'b0) begin
      next_cycle();
    end
    answer_pause();
    hs_out_ack = 1'b0;
  endtask

  task automatic end_frame();
    start = 1'b0;
    idle_cycles(GAP_CYCLES);  // lets the sequencer see start low in wait_release.
  endtask

  task automatic write_frame(input reg_addr_t addr, input word_t data);
    start = 1'b1;
    send_byte(WRITE_FLAG | cmd_t'(addr));
    for (int i = WORD_BYTES - 1; i >= 0; i--) begin
      send_byte(data[i*8 +: 8]);
    end
    end_frame();
    if (addr != COUNT_ADDR) begin
      ref_regs[addr] = data;
      ref_writes++;
    end
  endtask

  task automatic read_frame(input reg_addr_t addr, output word_t data);
    byte_t b;
    data  = '0;
    start = 1'b1;
    send_byte(cmd_t'(addr));
    for (int i = 0; i < WORD_BYTES; i++) begin
      receive_byte(b);
      data = {data[23:0], b};  // msb comes back first.
    end
    end_frame();
  endtask

  task automatic check_read(input reg_addr_t addr);
    word_t got;
    word_t expected;
    expected = (addr == COUNT_ADDR) ? ref_writes : ref_regs[addr];
    read_frame(addr, got);
    compare_word(got, expected, $sformatf("read of register %0d", addr));
  endtask

  task automatic check_handshake_idle(input string when);
    compare_bit(hs_in_ack, 1'b0, {"hs_in_ack ", when});
    compare_bit(hs_out_req, 1'b0, {"hs_out_req ", when});
    compare_bit(rw, 1'b0, {"rw ", when});
  endtask

  task automatic test_reset_state();
    check_handshake_idle("after reset");
    compare_byte(up_data_out, 8'h00, "up_data_out after reset");
  endtask

  task automatic test_write_read_reg3();
    write_frame(3'd3, 32'ha1b2_c3d4);
    check_read(3'd3);
  endtask

  task automatic test_random_words();
    reg_addr_t order [7];
    order = '{3'd5, 3'd2, 3'd6, 3'd0, 3'd3, 3'd1, 3'd4};
    for (int i = 0; i < 7; i++) begin
      write_frame(reg_addr_t'(i), $random(seed));
    end
    for (int i = 0; i < 7; i++) begin
      check_read(order[i]);
    end
  endtask

  task automatic test_write_count();
    check_read(COUNT_ADDR);
    write_frame(COUNT_ADDR, $random(seed));
    check_read(COUNT_ADDR);
  endtask

  // the frame is cut off after two data bytes, while the link still acks the third.
  task automatic test_soft_reset();
    start = 1'b1;
    send_byte(WRITE_FLAG | 8'h04);
    send_byte(8'hde);
    send_byte(8'had);
    up_data_in = 8'hbe;
    hs_in_req  = 1'b1;
    while (hs_in_ack !== 1'b1) begin
      next_cycle();
    end
    soft_reset = 1'b1;
    start      = 1'b0;
    idle_cycles(4);
    check_handshake_idle("during soft reset");
    soft_reset = 1'b0;
    hs_in_req  = 1'b0;
    idle_cycles(GAP_CYCLES);
    check_read(3'd4);
    write_frame(3'd4, $random(seed));
    check_read(3'd4);
  endtask

  task automatic test_slow_processor();
    max_delay = 15;
    write_frame(3'd1, $random(seed));
    write_frame(3'd5, $random(seed));
    write_frame(3'd6, $random(seed));
    check_read(3'd6);
    check_read(3'd1);
    check_read(3'd5);
    check_read(COUNT_ADDR);
    max_delay = 0;
  endtask

  initial begin
    seed       = 32'h6389_c878;
    reset      = 1'b0;
    soft_reset = 1'b0;
    start      = 1'b0;
    up_data_in = '0;
    hs_in_req  = 1'b0;
    hs_out_ack = 1'b0;
    ref_writes = '0;
    for (int i = 0; i < 8; i++) begin
      ref_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b1;
    idle_cycles(2);
    test_reset_state();
    test_write_read_reg3();
    test_random_words();
    test_write_count();
    test_soft_reset();
    test_slow_processor();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/up_link_top.sv */
// Top level of the processor link.
// Ties the byte port to the sequencer, and the sequencer to the register
// bank over an internal Wishbone classic bus.

`default_nettype none

module up_link_top import up_link_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  soft_reset,
  input  logic  start,
  input  byte_t up_data_in,
  input  logic  hs_in_req,
  input  logic  hs_out_ack,
  output byte_t up_data_out,
  output logic  rw,
  output logic  hs_in_ack,
  output logic  hs_out_req
);

  logic      start_s, hs_in_req_s, hs_out_ack_s;
  logic      count_zero, load_count, count_step;
  logic      shift_in, load_out_en, shift_out;
  cmd_t      rx_cmd;
  word_t     rx_word, load_out;
  logic      wb_cyc, wb_stb, wb_we, wb_ack;
  reg_addr_t wb_adr;
  word_t     wb_dat_w, wb_dat_r;

  up_byte_port #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_up_byte_port (
    .clk, .reset, .up_data_in, .start, .hs_in_req, .hs_out_ack,
    .load_count, .count_step, .shift_in, .load_out, .load_out_en, .shift_out,
    .start_s, .hs_in_req_s, .hs_out_ack_s, .count_zero,
    .rx_cmd, .rx_word, .up_data_out
  );

  up_interface_fsm u_up_interface_fsm (
    .clk, .reset, .soft_reset, .start_s, .hs_in_req_s, .hs_out_ack_s,
    .count_zero, .rx_cmd, .rx_word, .wb_dat_r, .wb_ack,
    .rw, .hs_in_ack, .hs_out_req, .load_count, .count_step, .shift_in,
    .load_out, .load_out_en, .shift_out,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w
  );

  wb_reg_bank u_wb_reg_bank (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack
  );

endmodule

`default_nettype wire

/* rtl/wb_reg_bank.sv */
// Wishbone classic slave behind the processor link.
// Seven read/write word registers at addresses 0..6, and a read-only count
// of completed writes at address 7. Each access is acknowledged after one
// wait cycle.

`default_nettype none

module wb_reg_bank import up_link_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  reg_addr_t wb_adr,
  input  word_t     wb_dat_w,
  output word_t     wb_dat_r,
  output logic      wb_ack
);

  localparam reg_addr_t COUNT_ADDR = 3'd7;
  localparam int NUM_REGS = 7;

  word_t regs [NUM_REGS];
  word_t write_count;
  logic  ack_q;

  // one pulse per access, even if the master keeps stb high.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc && wb_stb && !ack_q;
    end
  end

  assign wb_ack = ack_q && wb_cyc && wb_stb;  // falls with stb.

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      write_count <= '0;
    end else if (wb_ack && wb_we && wb_adr != COUNT_ADDR) begin
      regs[wb_adr] <= wb_dat_w;
      write_count  <= write_count + 1'b1;  // wraps at 32 bits.
    end
  end

  always_comb begin
    if (wb_adr == COUNT_ADDR) begin
      wb_dat_r = write_count;
    end else begin
      wb_dat_r = regs[wb_adr];
    end
  end

endmodule

`default_nettype wire

/* rtl/up_interface_fsm.sv */
// Moore sequencer for the processor link.
// Runs one frame per start pulse: takes the command byte, then four data
// bytes for a write, issues one Wishbone classic access, and returns four
// bytes for a read. soft_reset sends it back to idle from any state.

`default_nettype none

module up_interface_fsm import up_link_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      soft_reset,
  input  logic      start_s,
  input  logic      hs_in_req_s,
  input  logic      hs_out_ack_s,
  input  logic      count_zero,
  input  cmd_t      rx_cmd,
  input  word_t     rx_word,
  input  word_t     wb_dat_r,
  input  logic      wb_ack,
  output logic      rw,
  output logic      hs_in_ack,
  output logic      hs_out_req,
  output logic      load_count,
  output logic      count_step,
  output logic      shift_in,
  output word_t     load_out,
  output logic      load_out_en,
  output logic      shift_out,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output reg_addr_t wb_adr,
  output word_t     wb_dat_w
);

  link_state_t state, next_state;
  logic        is_write;

  assign is_write = rx_cmd[CMD_WRITE_BIT];

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin: set_next_state
    next_state = state;
    unique case (state)
      idle:
        next_state = start_s ? start_frame : idle;
      start_frame:
        next_state = recv_req;
      recv_req:
        next_state = hs_in_req_s ? recv_ack : recv_req;
      recv_ack:
        next_state = recv_done;
      recv_done:
        next_state = hs_in_req_s ? recv_done : decode;  // hold ack until req drops.
      decode:
        if (is_write && !count_zero) begin
          next_state = recv_req;
        end else begin
          next_state = bus_cycle;
        end
      bus_cycle:
        if (wb_ack) begin
          next_state = is_write ? wait_release : send_done;
        end
      send_done:
        next_state = send_req;
      send_req:
        next_state = hs_out_ack_s ? send_ack : send_req;
      send_ack:
        if (!hs_out_ack_s) begin
          next_state = count_zero ? wait_release : send_done;
        end
      wait_release:
        next_state = start_s ? wait_release : idle;
      default:
        next_state = idle;
    endcase
    if (soft_reset) begin
      next_state = idle;
    end
  end: set_next_state

  always_comb begin: set_outputs
    rw          = 1'b0;
    hs_in_ack   = 1'b0;
    hs_out_req  = 1'b0;
    load_count  = 1'b0;
    count_step  = 1'b0;
    shift_in    = 1'b0;
    load_out_en = 1'b0;
    shift_out   = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    case (state)
      start_frame: begin
        load_count = 1'b1;
      end
      recv_ack: begin
        hs_in_ack  = 1'b1;
        shift_in   = 1'b1;
        count_step = 1'b1;
      end
      recv_done: begin
        hs_in_ack = 1'b1;
      end
      bus_cycle: begin
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = is_write;
        load_out_en = 1'b1;  // the last load lands on the ack cycle.
        load_count  = 1'b1;
      end
      send_done: begin
        rw         = 1'b1;
        shift_out  = 1'b1;
        count_step = 1'b1;
      end
      send_req: begin
        rw         = 1'b1;
        hs_out_req = 1'b1;
      end
      send_ack: begin
        rw = 1'b1;
      end
      default: begin
      end
    endcase
  end: set_outputs

  assign load_out = wb_dat_r;
  assign wb_adr   = rx_cmd[$bits(reg_addr_t)-1:0];
  assign wb_dat_w = rx_word;

endmodule

`default_nettype wire

/* rtl/up_byte_port.sv */
// Byte-wide side of the processor link.
// Synchronizes the processor handshake inputs, counts bytes in a word and
// holds the receive and send shift registers that the sequencer steps.

`default_nettype none

module up_byte_port import up_link_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic  clk,
  input  logic  reset,
  input  byte_t up_data_in,
  input  logic  start,
  input  logic  hs_in_req,
  input  logic  hs_out_ack,
  input  logic  load_count,
  input  logic  count_step,
  input  logic  shift_in,
  input  word_t load_out,
  input  logic  load_out_en,
  input  logic  shift_out,
  output logic  start_s,
  output logic  hs_in_req_s,
  output logic  hs_out_ack_s,
  output logic  count_zero,
  output cmd_t  rx_cmd,
  output word_t rx_word,
  output byte_t up_data_out
);

  localparam int COUNT_W = $clog2(WORD_BYTES + 1);

  logic [2:0]         sync_q [SYNC_STAGES];
  logic [COUNT_W-1:0] byte_count;
  logic               cmd_next;
  word_t              send_word;

  // all three inputs ride the same chain of flops.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= {start, hs_in_req, hs_out_ack};
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign start_s      = sync_q[SYNC_STAGES-1][2];
  assign hs_in_req_s  = sync_q[SYNC_STAGES-1][1];
  assign hs_out_ack_s = sync_q[SYNC_STAGES-1][0];

  // the command byte is captured but not counted.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      byte_count <= '0;
      cmd_next   <= 1'b0;
    end else if (load_count) begin
      byte_count <= COUNT_W'(WORD_BYTES);
      cmd_next   <= 1'b1;
    end else begin
      if (shift_in) begin
        cmd_next <= 1'b0;
      end
      if (count_step && !count_zero && !(shift_in && cmd_next)) begin
        byte_count <= byte_count - 1'b1;
      end
    end
  end

  assign count_zero = (byte_count == '0);

  always_ff @(posedge clk) begin
    if (shift_in) begin
      if (cmd_next) begin
        rx_cmd <= up_data_in;
      end else begin
        rx_word <= {rx_word[23:0], up_data_in};  // msb arrives first.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_out_en) begin
      send_word <= load_out;
    end else if (shift_out) begin
      send_word <= send_word << 8;
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      up_data_out <= '0;
    end else if (shift_out) begin
      up_data_out <= send_word[31:24];
    end
  end

endmodule

`default_nettype wire

/* rtl/up_link_pkg.sv */
// Shared types and constants for the processor link.
// Imported with a wildcard by the byte port, the sequencer, the register bank
// and the top level.

`default_nettype none

package up_link_pkg;

  localparam int WORD_BYTES = 4;     // bytes per register word.
  localparam int CMD_WRITE_BIT = 7;  // set in the command byte for a write frame.

  typedef logic [7:0] byte_t;
  typedef logic [31:0] word_t;
  typedef logic [2:0] reg_addr_t;

  // bit 7 is the write flag, bits 2..0 are the register address.
  typedef logic [7:0] cmd_t;

  typedef enum logic [3:0] {
    idle,
    start_frame,
    recv_req,
    recv_ack,
    recv_done,
    decode,
    bus_cycle,
    send_req,
    send_ack,
    send_done,
    wait_release
  } link_state_t;

endpackage

`default_nettype wire
